//--- mpq_defs.svh
//////////////////////////////////////////////////
// Message queue engine parameters
// queue count, id width, FIFO depth and the
// field widths shared by the package and the RTL
//////////////////////////////////////////////////

`ifndef MPQ_DEFS_SVH
`define MPQ_DEFS_SVH

// number of message queues, one lane each
`define MPQ_NUM 8

// message id width, also the lane index width
`define MPQ_ID_W 3

// packets held in each private queue FIFO
`define MPQ_FIFO_DEPTH 4

// length and in-flight counters, enough for depth 4
`define MPQ_CNT_W 3

// packet and handler address width
`define MPQ_ADDR_W 32

// packet size width
`define MPQ_SIZE_W 16

`endif

//--- mpq_pkg.sv
//////////////////////////////////////////////////
// Message queue engine types
// queue state, packet, HER, feedback and task
// descriptors
//////////////////////////////////////////////////

`include "mpq_defs.svh"

package mpq_pkg;

    // handler sequence of one queue
    typedef enum logic [2:0] {
        Free,
        Header,
        HeaderRunning,
        Payload,
        PayloadDraining,
        Completion,
        CompletionRunning
    } mpq_state_e;

    typedef struct packed {
        logic [`MPQ_ADDR_W-1:0] pkt_addr;
        logic [`MPQ_SIZE_W-1:0] pkt_size;
    } pkt_t;

    // a zero header or completion address means no such handler
    typedef struct packed {
        logic [`MPQ_ADDR_W-1:0] hh_addr;
        logic [`MPQ_ADDR_W-1:0] ph_addr;
        logic [`MPQ_ADDR_W-1:0] th_addr;
    } handler_meta_t;

    typedef struct packed {
        logic [`MPQ_ID_W-1:0] msgid;
        pkt_t                 pkt;
        logic                 eom;
        handler_meta_t        meta;
    } her_descr_t;

    typedef struct packed {
        logic [`MPQ_ID_W-1:0] msgid;
        logic                 trigger_feedback;
    } feedback_descr_t;

    typedef struct packed {
        logic [`MPQ_ID_W-1:0]   msgid;
        logic [`MPQ_ADDR_W-1:0] handler_addr;
        pkt_t                   pkt;
        logic                   trigger_feedback;
    } handler_task_t;

endpackage

//--- mpq_if.sv
//////////////////////////////////////////////////
// Message queue engine interfaces
// events from the intake into a lane, and the
// task offer from a lane to the dispatcher
//////////////////////////////////////////////////

`include "mpq_defs.svh"

interface mpq_event_if;

    // one-cycle strobe, a HER for this lane was accepted
    logic                   push;
    mpq_pkg::her_descr_t    her;
    // one-cycle strobe, feedback for this lane was accepted
    logic                   feedback;
    // packet FIFO of the lane is full
    logic                   full;

    modport intake (
        output push,
        output her,
        output feedback,
        input  full
    );

    modport lane (
        input  push,
        input  her,
        input  feedback,
        output full
    );

endinterface

interface mpq_sched_if;

    logic                   ready;
    logic [`MPQ_ADDR_W-1:0] handler_addr;
    mpq_pkg::pkt_t          head;
    // task releases its packet, also its feedback trigger
    logic                   pops;
    // one-cycle strobe, the offered task was taken
    logic                   sent;

    modport lane (
        output ready,
        output handler_addr,
        output head,
        output pops,
        input  sent
    );

    modport dispatcher (
        input  ready,
        input  handler_addr,
        input  head,
        input  pops,
        output sent
    );

endinterface

//--- mpq_intake.sv
//////////////////////////////////////////////////
// Message queue intake
// steers accepted HERs and feedback to their lane
// and forwards feedback to the NIC
//////////////////////////////////////////////////

`include "mpq_defs.svh"

module mpq_intake (
    input  logic                     her_valid_i,
    input  mpq_pkg::her_descr_t      her_i,
    output logic                     her_ready_o,

    input  logic                     feedback_valid_i,
    input  mpq_pkg::feedback_descr_t feedback_i,
    output logic                     feedback_ready_o,

    input  logic                     nic_feedback_ready_i,
    output logic                     nic_feedback_valid_o,
    output mpq_pkg::feedback_descr_t nic_feedback_o,

    mpq_event_if.intake              ev [`MPQ_NUM]
);

    logic [`MPQ_NUM-1:0] full_vec;
    logic                her_fire;
    logic                fb_fire;

    // a HER only waits on the lane it is addressed to
    assign her_ready_o = !full_vec[her_i.msgid];
    assign her_fire    = her_valid_i && her_ready_o;

    assign feedback_ready_o = nic_feedback_ready_i;
    assign fb_fire          = feedback_valid_i && feedback_ready_o;

    // only feedback with the trigger set goes back to the NIC
    assign nic_feedback_valid_o = feedback_valid_i && feedback_i.trigger_feedback;
    assign nic_feedback_o       = feedback_i;

    for (genvar i = 0; i < `MPQ_NUM; i++) begin : gen_lane_ev
        assign full_vec[i]    = ev[i].full;
        assign ev[i].her      = her_i;
        assign ev[i].push     = her_fire && (her_i.msgid == (`MPQ_ID_W)'(i));
        assign ev[i].feedback = fb_fire && (feedback_i.msgid == (`MPQ_ID_W)'(i));
    end

endmodule

//--- mpq_lane.sv
//////////////////////////////////////////////////
// Message queue lane
// one queue with its packet FIFO, counters, latched
// handlers and the handler-sequence FSM
//////////////////////////////////////////////////

`include "mpq_defs.svh"

module mpq_lane (
    input  logic       clk_i,
    input  logic       rst_ni,
    mpq_event_if.lane  ev,
    mpq_sched_if.lane  sched
);

    localparam int PTR_W = $clog2(`MPQ_FIFO_DEPTH);

    mpq_pkg::pkt_t           fifo_mem [`MPQ_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [`MPQ_CNT_W-1:0]   fifo_cnt_q;
    logic                    fifo_pop;

    mpq_pkg::mpq_state_e     state_q, state_d;
    logic [`MPQ_CNT_W-1:0]   length_q, length_d;
    logic [`MPQ_CNT_W-1:0]   in_flight_q, in_flight_d;
    logic                    eom_seen_q, eom_seen_d;
    logic                    has_compl_q, has_compl_d;
    mpq_pkg::handler_meta_t  meta_q;

    logic                    payload_sent;
    logic                    last_pkt;

    assign payload_sent = sched.sent && (state_q == mpq_pkg::Payload);
    // the next undispatched packet closes the message
    assign last_pkt     = eom_seen_q && (length_q == `MPQ_CNT_W'd1);

    // offer towards the dispatcher
    assign sched.ready = (state_q == mpq_pkg::Header) ||
                         (state_q == mpq_pkg::Completion) ||
                         ((state_q == mpq_pkg::Payload) && (length_q != '0));
    assign sched.head  = fifo_mem[rd_ptr_q];

    always_comb begin
        case (state_q)
            mpq_pkg::Header:     sched.handler_addr = meta_q.hh_addr;
            mpq_pkg::Completion: sched.handler_addr = meta_q.th_addr;
            default:             sched.handler_addr = meta_q.ph_addr;
        endcase
    end

    // the eom packet stays queued for the completion handler
    assign sched.pops = ((state_q == mpq_pkg::Payload) && !(last_pkt && has_compl_q)) ||
                        (state_q == mpq_pkg::Completion);

    assign fifo_pop = sched.sent && sched.pops;
    assign ev.full  = (fifo_cnt_q == `MPQ_CNT_W'(`MPQ_FIFO_DEPTH));

    always_comb begin
        case ({ev.push, payload_sent})
            2'b10:   length_d = length_q + 1'b1;
            2'b01:   length_d = length_q - 1'b1;
            default: length_d = length_q;
        endcase
    end

    always_comb begin
        case ({sched.sent, ev.feedback})
            2'b10:   in_flight_d = in_flight_q + 1'b1;
            2'b01:   in_flight_d = in_flight_q - 1'b1;
            default: in_flight_d = in_flight_q;
        endcase
    end

    always_comb begin
        state_d     = state_q;
        has_compl_d = has_compl_q;
        eom_seen_d  = eom_seen_q || (ev.push && ev.her.eom);
        case (state_q)
            mpq_pkg::Free: begin
                if (ev.push) begin
                    state_d     = (ev.her.meta.hh_addr != '0) ? mpq_pkg::Header
                                                              : mpq_pkg::Payload;
                    has_compl_d = (ev.her.meta.th_addr != '0);
                end
            end
            mpq_pkg::Header: begin
                if (sched.sent) state_d = mpq_pkg::HeaderRunning;
            end
            mpq_pkg::HeaderRunning: begin
                if (ev.feedback) state_d = mpq_pkg::Payload;
            end
            mpq_pkg::Payload: begin
                if (sched.sent && last_pkt) state_d = mpq_pkg::PayloadDraining;
            end
            mpq_pkg::PayloadDraining: begin
                // wait for the last outstanding payload task
                if (ev.feedback && (in_flight_q == `MPQ_CNT_W'd1)) begin
                    state_d = has_compl_q ? mpq_pkg::Completion : mpq_pkg::Free;
                end
            end
            mpq_pkg::Completion: begin
                if (sched.sent) state_d = mpq_pkg::CompletionRunning;
            end
            mpq_pkg::CompletionRunning: begin
                if (ev.feedback) state_d = mpq_pkg::Free;
            end
            default: state_d = mpq_pkg::Free;
        endcase
        // message done, next one starts clean
        if (state_d == mpq_pkg::Free) eom_seen_d = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= mpq_pkg::Free;
            length_q    <= '0;
            in_flight_q <= '0;
            eom_seen_q  <= 1'b0;
            has_compl_q <= 1'b0;
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            fifo_cnt_q  <= '0;
        end else begin
            state_q     <= state_d;
            length_q    <= length_d;
            in_flight_q <= in_flight_d;
            eom_seen_q  <= eom_seen_d;
            has_compl_q <= has_compl_d;
            if (ev.push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (fifo_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({ev.push, fifo_pop})
                2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
                2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
                default: fifo_cnt_q <= fifo_cnt_q;
            endcase
        end
    end

    // packet storage and handlers latched by the first HER of a message
    always_ff @(posedge clk_i) begin
        if (ev.push) fifo_mem[wr_ptr_q] <= ev.her.pkt;
        if (ev.push && (state_q == mpq_pkg::Free)) meta_q <= ev.her.meta;
    end

endmodule

//--- mpq_dispatch.sv
//////////////////////////////////////////////////
// Message queue dispatcher
// round-robin grant over ready lanes and the held
// output task register
//////////////////////////////////////////////////

`include "mpq_defs.svh"

module mpq_dispatch (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    mpq_sched_if.dispatcher        sched [`MPQ_NUM],
    input  logic                   task_ready_i,
    output logic                   task_valid_o,
    output mpq_pkg::handler_task_t task_o
);

    logic [`MPQ_NUM-1:0]     ready_vec;
    logic [`MPQ_NUM-1:0]     pops_vec;
    logic [`MPQ_ADDR_W-1:0]  addr_vec [`MPQ_NUM];
    mpq_pkg::pkt_t           head_vec [`MPQ_NUM];

    logic [`MPQ_ID_W-1:0]    ptr_q;
    logic [`MPQ_ID_W-1:0]    grant_idx;
    logic                    grant_found;
    logic                    grant;

    logic                    valid_q;
    mpq_pkg::handler_task_t  task_q, task_d;

    for (genvar i = 0; i < `MPQ_NUM; i++) begin : gen_lane_sched
        assign ready_vec[i]  = sched[i].ready;
        assign pops_vec[i]   = sched[i].pops;
        assign addr_vec[i]   = sched[i].handler_addr;
        assign head_vec[i]   = sched[i].head;
        assign sched[i].sent = grant && (grant_idx == (`MPQ_ID_W)'(i));
    end

    // first ready lane at or after the pointer
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < `MPQ_NUM; k++) begin
            idx = (int'(ptr_q) + k) % `MPQ_NUM;
            if (!grant_found && ready_vec[idx]) begin
                grant_found = 1'b1;
                grant_idx   = idx[`MPQ_ID_W-1:0];
            end
        end
    end

    // a held task blocks further grants until it is taken
    assign grant = grant_found && (!valid_q || task_ready_i);

    always_comb begin
        task_d.msgid            = grant_idx;
        task_d.handler_addr     = addr_vec[grant_idx];
        task_d.pkt              = head_vec[grant_idx];
        task_d.trigger_feedback = pops_vec[grant_idx];
    end

    assign task_valid_o = valid_q;
    assign task_o       = task_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            ptr_q   <= '0;
        end else begin
            if (grant) begin
                valid_q <= 1'b1;
                ptr_q   <= (grant_idx == (`MPQ_ID_W)'(`MPQ_NUM - 1)) ? '0
                                                                     : grant_idx + 1'b1;
            end else if (task_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grant) task_q <= task_d;
    end

endmodule

//--- mpq_engine.sv
//////////////////////////////////////////////////
// Message processing queue engine
// sorts HERs into per-message queues and issues
// header, payload and completion handler tasks
//////////////////////////////////////////////////

`include "mpq_defs.svh"

module mpq_engine (
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     her_valid_i,
    input  mpq_pkg::her_descr_t      her_i,
    output logic                     her_ready_o,
    output logic [`MPQ_NUM-1:0]      mpq_full_o,

    input  logic                     feedback_valid_i,
    input  mpq_pkg::feedback_descr_t feedback_i,
    output logic                     feedback_ready_o,

    input  logic                     task_ready_i,
    output logic                     task_valid_o,
    output mpq_pkg::handler_task_t   task_o,

    input  logic                     nic_feedback_ready_i,
    output logic                     nic_feedback_valid_o,
    output mpq_pkg::feedback_descr_t nic_feedback_o
);

    mpq_event_if ev_if    [`MPQ_NUM] ();
    mpq_sched_if sched_if [`MPQ_NUM] ();

    mpq_intake intake_i (
        .her_valid_i          (her_valid_i),
        .her_i                (her_i),
        .her_ready_o          (her_ready_o),
        .feedback_valid_i     (feedback_valid_i),
        .feedback_i           (feedback_i),
        .feedback_ready_o     (feedback_ready_o),
        .nic_feedback_ready_i (nic_feedback_ready_i),
        .nic_feedback_valid_o (nic_feedback_valid_o),
        .nic_feedback_o       (nic_feedback_o),
        .ev                   (ev_if)
    );

    for (genvar i = 0; i < `MPQ_NUM; i++) begin : gen_lane
        mpq_lane lane_i (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .ev     (ev_if[i]),
            .sched  (sched_if[i])
        );
        assign mpq_full_o[i] = ev_if[i].full;
    end

    mpq_dispatch dispatch_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .sched        (sched_if),
        .task_ready_i (task_ready_i),
        .task_valid_o (task_valid_o),
        .task_o       (task_o)
    );

endmodule

//--- tb_mpq_engine.sv
//////////////////////////////////////////////////
// Message queue engine testbench
// drives HERs and feedback, models the scheduler
// and checks tasks against a per-id reference
//////////////////////////////////////////////////

`include "mpq_defs.svh"

module tb_mpq_engine;

    localparam int NUM_TESTS = 5;
    localparam int PERIOD    = 100;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     her_valid_i;
    mpq_pkg::her_descr_t      her_i;
    logic                     her_ready_o;
    logic [`MPQ_NUM-1:0]      mpq_full_o;
    logic                     feedback_valid_i;
    mpq_pkg::feedback_descr_t feedback_i;
    logic                     feedback_ready_o;
    logic                     task_ready_i;
    logic                     task_valid_o;
    mpq_pkg::handler_task_t   task_o;
    logic                     nic_feedback_ready_i;
    logic                     nic_feedback_valid_o;
    mpq_pkg::feedback_descr_t nic_feedback_o;

    // current message of each id
    int msg_npk [`MPQ_NUM];
    int msg_seq [`MPQ_NUM];
    bit msg_hh [`MPQ_NUM];
    bit msg_th [`MPQ_NUM];
    int pushed [`MPQ_NUM];
    int sent_cnt [`MPQ_NUM];
    int fb_cnt [`MPQ_NUM];

    mpq_pkg::feedback_descr_t fb_q [$];
    int                       due_q [$];
    int  cycle;
    int  errors;
    int  tests_passed;
    int  tests_failed;
    bit  hold;
    bit  rand_ready;

    mpq_engine mpq_engine_i (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .her_valid_i          (her_valid_i),
        .her_i                (her_i),
        .her_ready_o          (her_ready_o),
        .mpq_full_o           (mpq_full_o),
        .feedback_valid_i     (feedback_valid_i),
        .feedback_i           (feedback_i),
        .feedback_ready_o     (feedback_ready_o),
        .task_ready_i         (task_ready_i),
        .task_valid_o         (task_valid_o),
        .task_o               (task_o),
        .nic_feedback_ready_i (nic_feedback_ready_i),
        .nic_feedback_valid_o (nic_feedback_valid_o),
        .nic_feedback_o       (nic_feedback_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(NUM_TESTS * 2000 * PERIOD);
        $display("timeout, the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    function automatic mpq_pkg::pkt_t pkt_of(input int id, input int k);
        mpq_pkg::pkt_t p;
        p.pkt_addr = 32'h8000_0000 + 32'(id) * 32'h1_0000 + 32'(msg_seq[id]) * 32'h100
                   + 32'(k) * 32'h10;
        p.pkt_size = 16'(64 + 8 * k + id);
        return p;
    endfunction

    function automatic mpq_pkg::handler_meta_t meta_of(input int id);
        mpq_pkg::handler_meta_t m;
        m.hh_addr = msg_hh[id] ? 32'h1000_0000 + 32'(id) * 32'h1000 + 32'(msg_seq[id]) : '0;
        m.ph_addr = 32'h2000_0000 + 32'(id) * 32'h1000 + 32'(msg_seq[id]);
        m.th_addr = msg_th[id] ? 32'h3000_0000 + 32'(id) * 32'h1000 + 32'(msg_seq[id]) : '0;
        return m;
    endfunction

    function automatic int n_tasks(input int id);
        return msg_npk[id] + int'(msg_hh[id]) + int'(msg_th[id]);
    endfunction

    // header, then one payload per packet, then completion on the eom packet
    function automatic mpq_pkg::handler_task_t expected_task(input int msg, input int index);
        mpq_pkg::handler_task_t t;
        mpq_pkg::handler_meta_t m;
        int                     k;
        m       = meta_of(msg);
        k       = msg_hh[msg] ? index - 1 : index;
        t.msgid = (`MPQ_ID_W)'(msg);
        if (k < 0) begin
            t.handler_addr     = m.hh_addr;
            t.pkt              = pkt_of(msg, 0);
            t.trigger_feedback = 1'b0;
        end else if (k < msg_npk[msg]) begin
            t.handler_addr     = m.ph_addr;
            t.pkt              = pkt_of(msg, k);
            t.trigger_feedback = !((k == msg_npk[msg] - 1) && msg_th[msg]);
        end else begin
            t.handler_addr     = m.th_addr;
            t.pkt              = pkt_of(msg, msg_npk[msg] - 1);
            t.trigger_feedback = 1'b1;
        end
        return t;
    endfunction

    task automatic check_task(input string name, input mpq_pkg::handler_task_t got,
                              input mpq_pkg::handler_task_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_feedback(input string name, input mpq_pkg::feedback_descr_t got,
                                  input mpq_pkg::feedback_descr_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // scheduler model that checks each accepted task and returns its feedback later
    initial begin : scheduler_model
        int                       id;
        mpq_pkg::feedback_descr_t fb;
        task_ready_i         = 1'b0;
        feedback_valid_i     = 1'b0;
        feedback_i           = '0;
        nic_feedback_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            cycle++;
            if (rst_ni) begin
                check_flag("feedback_ready_o", feedback_ready_o, nic_feedback_ready_i);
                check_flag("nic_feedback_valid_o", nic_feedback_valid_o,
                           feedback_valid_i && feedback_i.trigger_feedback);
                if (feedback_valid_i) begin
                    check_feedback("nic_feedback_o", nic_feedback_o, feedback_i);
                end
                if (feedback_valid_i && feedback_ready_o) begin
                    fb_cnt[feedback_i.msgid]++;
                    void'(fb_q.pop_front());
                    void'(due_q.pop_front());
                end
                if (task_valid_o && task_ready_i) begin
                    id = int'(task_o.msgid);
                    if (sent_cnt[id] >= n_tasks(id)) begin
                        errors++;
                        $display("unexpected task for message id %0d", id);
                    end else begin
                        check_task("task_o", task_o, expected_task(id, sent_cnt[id]));
                        sent_cnt[id]++;
                    end
                    fb.msgid            = task_o.msgid;
                    fb.trigger_feedback = task_o.trigger_feedback;
                    fb_q.push_back(fb);
                    due_q.push_back(cycle + 1 + int'($urandom % 6));
                end
            end
            @(negedge clk_i);
            task_ready_i = hold ? 1'b0 : (rand_ready ? ($urandom % 4 != 0) : 1'b1);
            nic_feedback_ready_i = rand_ready ? ($urandom % 4 != 0) : 1'b1;
            if (fb_q.size() > 0 && due_q[0] <= cycle) begin
                feedback_valid_i = 1'b1;
                feedback_i       = fb_q[0];
            end else begin
                feedback_valid_i = 1'b0;
            end
        end
    end

    task automatic start_message(input int id, input int npk, input bit hh, input bit th);
        msg_seq[id]++;
        msg_npk[id]  = npk;
        msg_hh[id]   = hh;
        msg_th[id]   = th;
        pushed[id]   = 0;
        sent_cnt[id] = 0;
        fb_cnt[id]   = 0;
    endtask

    // starts and ends on a falling edge
    task automatic send_her(input int id, input int k);
        her_valid_i = 1'b1;
        her_i.msgid = (`MPQ_ID_W)'(id);
        her_i.pkt   = pkt_of(id, k);
        her_i.eom   = (k == msg_npk[id] - 1);
        her_i.meta  = meta_of(id);
        do @(posedge clk_i); while (!her_ready_o);
        @(negedge clk_i);
        her_valid_i = 1'b0;
    endtask

    task automatic send_message(input int id);
        while (pushed[id] < msg_npk[id]) begin
            send_her(id, pushed[id]);
            pushed[id]++;
        end
    endtask

    function automatic bit msg_done(input int id);
        return (pushed[id] == msg_npk[id]) && (fb_cnt[id] == n_tasks(id));
    endfunction

    task automatic wait_done(input int id);
        while (!msg_done(id)) @(negedge clk_i);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin : main
        int  e0;
        int  id;
        int  left [`MPQ_NUM];
        bit  busy;
        void'($urandom(70556));
        rst_ni      = 1'b0;
        her_valid_i = 1'b0;
        her_i       = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        e0 = errors;
        @(posedge clk_i);
        check_flag("task_valid_o", task_valid_o, 1'b0);
        check_flag("nic_feedback_valid_o", nic_feedback_valid_o, 1'b0);
        check_flag("her_ready_o", her_ready_o, 1'b1);
        @(negedge clk_i);
        start_message(1, 3, 1'b1, 1'b1);
        send_message(1);
        wait_done(1);
        report_test("full sequence", e0);

        e0 = errors;
        start_message(4, 2, 1'b0, 1'b0);
        send_message(4);
        wait_done(4);
        start_message(4, 3, 1'b0, 1'b0);
        send_message(4);
        wait_done(4);
        report_test("payload only", e0);

        e0   = errors;
        hold = 1'b1;
        @(negedge clk_i);
        start_message(2, `MPQ_FIFO_DEPTH, 1'b1, 1'b1);
        send_message(2);
        her_i.msgid = 3'd2;
        @(posedge clk_i);
        check_flag("mpq_full_o[2]", mpq_full_o[2], 1'b1);
        check_flag("her_ready_o", her_ready_o, 1'b0);
        @(negedge clk_i);
        her_i.msgid = 3'd5;
        @(posedge clk_i);
        check_flag("her_ready_o", her_ready_o, 1'b1);
        @(negedge clk_i);
        start_message(5, 1, 1'b0, 1'b0);
        send_message(5);
        report_test("full queue", e0);

        // header task of id 2 is the one held
        e0 = errors;
        repeat (8) begin
            @(posedge clk_i);
            check_flag("task_valid_o", task_valid_o, 1'b1);
            check_task("task_o", task_o, expected_task(2, 0));
        end
        @(negedge clk_i);
        hold = 1'b0;
        wait_done(2);
        wait_done(5);
        report_test("held task", e0);

        e0         = errors;
        rand_ready = 1'b1;
        for (int i = 0; i < `MPQ_NUM; i++) left[i] = 3;
        busy = 1'b1;
        while (busy) begin
            id = int'($urandom % `MPQ_NUM);
            if (pushed[id] < msg_npk[id]) begin
                send_her(id, pushed[id]);
                pushed[id]++;
            end else if (left[id] > 0 && msg_done(id)) begin
                start_message(id, 1 + int'($urandom % 4), 1'($urandom), 1'($urandom));
                left[id]--;
            end else begin
                @(negedge clk_i);
            end
            busy = 1'b0;
            for (int i = 0; i < `MPQ_NUM; i++) begin
                if (left[i] > 0 || !msg_done(i)) busy = 1'b1;
            end
        end
        report_test("random interleaving", e0);

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
mpq_pkg.sv
mpq_if.sv
mpq_intake.sv
mpq_lane.sv
mpq_dispatch.sv
mpq_engine.sv
tb_mpq_engine.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_mpq_engine
FILELIST  = sim.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
